// File: include/outrun_defs.svh
`ifndef OUTRUN_DEFS_SVH
`define OUTRUN_DEFS_SVH

// Top address byte of the mapper register window
`define OUTRUN_MAP_PAGE  8'hFE

// Number of programmable regions
`define OUTRUN_REGIONS   6

// Base bytes loaded on reset
`define OUTRUN_BASE0     8'h00
`define OUTRUN_BASE1     8'h40
`define OUTRUN_BASE2     8'h84
`define OUTRUN_BASE3     8'h90
`define OUTRUN_BASE4     8'hC4
`define OUTRUN_BASE5     8'hFF

// A18:A17 value for work RAM inside the memory region
`define OUTRUN_RAM_BITS  2'b11

// Entries in the decryption key table
`define OUTRUN_KEY_DEPTH 256

// Bit positions in the one-hot region vector
`define OUTRUN_REG_MEM   0
`define OUTRUN_REG_SCR   1
`define OUTRUN_REG_PAL   2
`define OUTRUN_REG_OBJ   3
`define OUTRUN_REG_IO    4

`endif

// File: source/outrun_pkg.sv
package outrun_pkg;

    // Word address, A0 is implied by the data strobes
    typedef logic [23:1] addr_t;

    // 16-bit bus data
    typedef logic [15:0] word_t;

    // Key entries and mapper registers
    typedef logic [7:0] byte_t;

    // One-hot active region
    // 0 memory, 1 scroll/char, 2 palette, 3 object, 4 I/O, 5 sub
    typedef logic [5:0] region_t;

    // DTACK generator states
    typedef enum logic [1:0] {
        dt_idle,
        dt_wait,
        dt_ack
    } dtack_state_t;

endpackage

// File: source/cpu_bus_if.sv
`timescale 1ns/1ps

// 68000-style bus as seen from the board logic
interface cpu_bus_if import outrun_pkg::*; ();

    addr_t       addr;
    word_t       wdata;
    logic        rnw;
    logic        asn;
    // Upper and lower data strobes, active low
    logic [1:0]  dsn;

    modport master (
        output addr,
        output wdata,
        output rnw,
        output asn,
        output dsn
    );

    modport slave (
        input  addr,
        input  wdata,
        input  rnw,
        input  asn,
        input  dsn
    );

endinterface

// File: source/outrun_mapper.sv
`timescale 1ns/1ps
`include "outrun_defs.svh"

module outrun_mapper import outrun_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    cpu_bus_if.slave    bus,
    output region_t     active,
    output logic        map_hit,
    output byte_t       map_rdata
);

    byte_t       base [`OUTRUN_REGIONS];
    logic [2:0]  map_idx;
    logic        map_valid;
    logic        map_we;

    // Register window lives in its own page
    assign map_hit   = bus.addr[23:16] == `OUTRUN_MAP_PAGE;
    assign map_idx   = bus.addr[3:1];
    assign map_valid = map_idx < `OUTRUN_REGIONS;

    // Low byte lane write into the window
    assign map_we = map_hit && map_valid && !bus.asn && !bus.rnw && !bus.dsn[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base[0] <= `OUTRUN_BASE0;
            base[1] <= `OUTRUN_BASE1;
            base[2] <= `OUTRUN_BASE2;
            base[3] <= `OUTRUN_BASE3;
            base[4] <= `OUTRUN_BASE4;
            base[5] <= `OUTRUN_BASE5;
        end else if (map_we) begin
            base[map_idx] <= bus.wdata[7:0];
        end
    end

    // Read back, unused slots float high
    always_comb begin
        if (map_valid) begin
            map_rdata = base[map_idx];
        end else begin
            map_rdata = 8'hFF;
        end
    end

    // Region match on A23:A16
    // Walk from the top so that the lowest index overrides
    always_comb begin
        active = '0;
        for (int n = `OUTRUN_REGIONS - 1; n >= 0; n--) begin
            if (bus.addr[23:16] == base[n]) begin
                active = region_t'(1) << n;
            end
        end
        // The window page is never a region
        if (map_hit) begin
            active = '0;
        end
    end

endmodule

// File: source/outrun_rom_decrypt.sv
`timescale 1ns/1ps
`include "outrun_defs.svh"

module outrun_rom_decrypt import outrun_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  addr_t  rom_addr,
    input  word_t  rom_data,
    input  logic   rom_ok,
    input  logic   dec_en,

    // Key table loading
    input  logic   prog_we,
    input  byte_t  prog_addr,
    input  byte_t  prog_data,

    output word_t  dec_data,
    output logic   dec_ok
);

    byte_t  key_mem [`OUTRUN_KEY_DEPTH];
    byte_t  key;
    word_t  plain;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            key_mem[prog_addr] <= prog_data;
        end
    end

    // One key byte per word address, A8:A1
    assign key = key_mem[rom_addr[8:1]];

    // Same key applied to both byte lanes
    assign plain = dec_en ? (rom_data ^ {key, key}) : rom_data;

    always_ff @(posedge clk) begin
        dec_data <= plain;
    end

    // ok tracks the data register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_ok <= 1'b0;
        end else begin
            dec_ok <= rom_ok;
        end
    end

endmodule

// File: source/outrun_dtack.sv
`timescale 1ns/1ps

module outrun_dtack import outrun_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    cpu_bus_if.slave    bus,
    input  logic        cs_any,
    input  logic        sel_ready,
    output logic        dtackn
);

    dtack_state_t  state;
    dtack_state_t  state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            dt_idle: begin
                if (!bus.asn) begin
                    state_nxt = dt_wait;
                end
            end
            dt_wait: begin
                // Master gave up the cycle
                if (bus.asn) begin
                    state_nxt = dt_idle;
                end else if (cs_any && sel_ready) begin
                    state_nxt = dt_ack;
                end
            end
            dt_ack: begin
                if (bus.asn) begin
                    state_nxt = dt_idle;
                end
            end
            default: begin
                state_nxt = dt_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= dt_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Low for the whole acknowledge state
    assign dtackn = state != dt_ack;

endmodule

// File: source/outrun_main_decode.sv
`timescale 1ns/1ps
`include "outrun_defs.svh"

module outrun_main_decode import outrun_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    cpu_bus_if.slave    bus,
    input  region_t     active,
    input  logic        map_hit,
    input  byte_t       map_rdata,

    // Chip selects
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        vram_cs,
    output logic        char_cs,
    output logic        pal_cs,
    output logic        objram_cs,
    output logic        io_hit,
    // Mapper window or unmapped access
    output logic        acc_hit,

    // Device data
    input  word_t       dec_data,
    input  logic        dec_ok,
    input  word_t       ram_data,
    input  logic        ram_ok,
    input  word_t       char_dout,
    input  word_t       pal_dout,
    input  word_t       obj_dout,
    input  byte_t       joystick1,
    input  byte_t       dipsw,

    output word_t       cpu_din,
    output logic        sel_ready
);

    logic  map_sel;
    logic  mem_hit;
    logic  any_sel;

    assign mem_hit = active[`OUTRUN_REG_MEM];

    // Selects follow the address strobe, one clock late
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_hit    <= 1'b0;
            map_sel   <= 1'b0;
            acc_hit   <= 1'b0;
        end else if (!bus.asn) begin
            rom_cs    <= mem_hit && bus.addr[18:17] != `OUTRUN_RAM_BITS;
            ram_cs    <= mem_hit && bus.addr[18:17] == `OUTRUN_RAM_BITS;
            char_cs   <= active[`OUTRUN_REG_SCR] && bus.addr[16];
            vram_cs   <= active[`OUTRUN_REG_SCR] && !bus.addr[16];
            pal_cs    <= active[`OUTRUN_REG_PAL];
            objram_cs <= active[`OUTRUN_REG_OBJ];
            io_hit    <= active[`OUTRUN_REG_IO];
            map_sel   <= map_hit;
            // Window and sub region both answer at once with no device
            acc_hit   <= ~|active[4:0];
        end else begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_hit    <= 1'b0;
            map_sel   <= 1'b0;
            acc_hit   <= 1'b0;
        end
    end

    assign any_sel = rom_cs | ram_cs | vram_cs | char_cs | pal_cs | objram_cs | io_hit | acc_hit;

    // Only ROM and RAM can hold the cycle
    assign sel_ready = !(rom_cs && !dec_ok) && !((ram_cs || vram_cs) && !ram_ok);

    // Read data, held between accesses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= '0;
        end else if (any_sel) begin
            if (ram_cs || vram_cs)   cpu_din <= ram_data;
            else if (rom_cs)         cpu_din <= dec_data;
            else if (char_cs)        cpu_din <= char_dout;
            else if (pal_cs)         cpu_din <= pal_dout;
            else if (objram_cs)      cpu_din <= obj_dout;
            else if (io_hit)         cpu_din <= {dipsw, joystick1};
            else if (map_sel)        cpu_din <= {8'hFF, map_rdata};
            else                     cpu_din <= 16'hFFFF;
        end
    end

endmodule

// File: source/outrun_main.sv
`timescale 1ns/1ps

module outrun_main import outrun_pkg::*; (
    input  logic         clk,
    input  logic         rst,

    // Bus master
    input  addr_t        cpu_addr,
    input  word_t        cpu_wdata,
    input  logic         cpu_rnw,
    input  logic         cpu_asn,
    input  logic [1:0]   cpu_dsn,
    output word_t        cpu_din,
    output logic         cpu_dtackn,

    // Program ROM
    output logic         rom_cs,
    output addr_t        rom_addr,
    input  word_t        rom_data,
    input  logic         rom_ok,

    // Work RAM and video RAM share one port
    output logic         ram_cs,
    output logic         vram_cs,
    input  word_t        ram_data,
    input  logic         ram_ok,

    // Video memories
    output logic         char_cs,
    output logic         pal_cs,
    output logic         objram_cs,
    input  word_t        char_dout,
    input  word_t        pal_dout,
    input  word_t        obj_dout,

    // Cabinet
    input  byte_t        joystick1,
    input  byte_t        dipsw,

    // Decryption setup
    input  logic         dec_en,
    input  logic         prog_we,
    input  byte_t        prog_addr,
    input  byte_t        prog_data,

    // Shared memory bus
    output logic [19:1]  bus_addr,
    output word_t        bus_wdata,
    output logic         bus_rnw
);

    region_t  active;
    logic     map_hit;
    byte_t    map_rdata;
    word_t    dec_data;
    logic     dec_ok;
    logic     io_hit;
    logic     acc_hit;
    logic     sel_ready;
    logic     cs_any;

    cpu_bus_if bus ();

    assign bus.addr  = cpu_addr;
    assign bus.wdata = cpu_wdata;
    assign bus.rnw   = cpu_rnw;
    assign bus.asn   = cpu_asn;
    assign bus.dsn   = cpu_dsn;

    assign rom_addr  = bus.addr;
    assign bus_addr  = bus.addr[19:1];
    assign bus_wdata = bus.wdata;
    assign bus_rnw   = bus.rnw;

    assign cs_any = rom_cs | ram_cs | vram_cs | char_cs | pal_cs | objram_cs | io_hit | acc_hit;

    outrun_mapper u_mapper (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus.slave),
        .active    (active),
        .map_hit   (map_hit),
        .map_rdata (map_rdata)
    );

    outrun_main_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus.slave),
        .active    (active),
        .map_hit   (map_hit),
        .map_rdata (map_rdata),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_hit    (io_hit),
        .acc_hit   (acc_hit),
        .dec_data  (dec_data),
        .dec_ok    (dec_ok),
        .ram_data  (ram_data),
        .ram_ok    (ram_ok),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .joystick1 (joystick1),
        .dipsw     (dipsw),
        .cpu_din   (cpu_din),
        .sel_ready (sel_ready)
    );

    outrun_rom_decrypt u_decrypt (
        .clk       (clk),
        .rst       (rst),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .dec_en    (dec_en),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .dec_data  (dec_data),
        .dec_ok    (dec_ok)
    );

    outrun_dtack u_dtack (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus.slave),
        .cs_any    (cs_any),
        .sel_ready (sel_ready),
        .dtackn    (cpu_dtackn)
    );

endmodule

// File: tb/outrun_main_tb.sv
`timescale 1ns/1ps
`include "outrun_defs.svh"

module outrun_main_tb import outrun_pkg::*; ();

    typedef enum logic [3:0] {
        sel_none, sel_rom, sel_ram, sel_vram, sel_char, sel_pal, sel_obj, sel_io, sel_map
    } sel_t;

    typedef struct packed {
        logic         rnw;
        logic         dec;
        logic [23:0]  addr;
        word_t        wdata;
        sel_t         sel;
        word_t        rdata;
    } entry_t;

    localparam int    KEYS      = 16;
    localparam word_t CHAR_WORD = 16'hC4A5;
    localparam word_t PAL_WORD  = 16'h7E01;
    localparam word_t OBJ_WORD  = 16'h0B3D;
    localparam byte_t JOY_BYTE  = 8'h3C;
    localparam byte_t DIP_BYTE  = 8'hA7;

    logic         clk;
    logic         rst;
    addr_t        cpu_addr;
    word_t        cpu_wdata;
    logic         cpu_rnw;
    logic         cpu_asn;
    logic [1:0]   cpu_dsn;
    word_t        cpu_din;
    logic         cpu_dtackn;
    logic         rom_cs;
    addr_t        rom_addr;
    word_t        rom_data;
    logic         rom_ok = 1'b0;
    logic         ram_cs;
    logic         vram_cs;
    word_t        ram_data;
    logic         ram_ok = 1'b0;
    logic         char_cs;
    logic         pal_cs;
    logic         objram_cs;
    word_t        char_dout;
    word_t        pal_dout;
    word_t        obj_dout;
    byte_t        joystick1;
    byte_t        dipsw;
    logic         dec_en;
    logic         prog_we;
    byte_t        prog_addr;
    byte_t        prog_data;
    logic [19:1]  bus_addr;
    word_t        bus_wdata;
    logic         bus_rnw;

    entry_t       tests[$];
    byte_t        key_tab [256];
    logic [31:0]  lfsr;
    int           cycle = 0;
    int           limit = 0;
    logic [2:0]   rom_delay = '0;
    logic [2:0]   ram_delay = '0;
    logic [2:0]   rom_wait = '0;
    logic [2:0]   ram_wait = '0;
    int           rom_ok_cyc = 0;
    int           ram_ok_cyc = 0;

    outrun_main UUT (.*);

    // Memory models
    assign rom_data  = rom_addr[16:1] ^ 16'h5A5A;
    assign ram_data  = bus_addr[16:1] ^ 16'h1234;
    assign char_dout = CHAR_WORD;
    assign pal_dout  = PAL_WORD;
    assign obj_dout  = OBJ_WORD;
    assign joystick1 = JOY_BYTE;
    assign dipsw     = DIP_BYTE;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            fail_now("Timeout: the bus cycle never completed");
        end
    end

    // ROM ok rises after the drawn delay once rom_cs is seen
    always @(posedge clk) begin
        if (rom_cs && !rom_ok) begin
            if (rom_wait == rom_delay) begin
                rom_ok     <= 1'b1;
                rom_ok_cyc <= cycle + 1;
            end else begin
                rom_wait <= rom_wait + 3'd1;
            end
        end else if (!rom_cs) begin
            rom_ok   <= 1'b0;
            rom_wait <= '0;
        end
    end

    // Work RAM and VRAM share one ok
    always @(posedge clk) begin
        if ((ram_cs || vram_cs) && !ram_ok) begin
            if (ram_wait == ram_delay) begin
                ram_ok     <= 1'b1;
                ram_ok_cyc <= cycle + 1;
            end else begin
                ram_wait <= ram_wait + 3'd1;
            end
        end else if (!(ram_cs || vram_cs)) begin
            ram_ok   <= 1'b0;
            ram_wait <= '0;
        end
    end

    task fail_now(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            lfsr_next = (s >> 1) ^ 32'h80200003;
        end else begin
            lfsr_next = s >> 1;
        end
    endfunction

    task draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    // Expected words from the model rules
    function automatic word_t rom_word(input logic [23:0] a);
        rom_word = a[16:1] ^ 16'h5A5A;
    endfunction

    function automatic word_t ram_word(input logic [23:0] a);
        ram_word = a[16:1] ^ 16'h1234;
    endfunction

    function automatic word_t rom_crypt(input logic [23:0] a);
        byte_t k;
        k = key_tab[a[8:1]];
        rom_crypt = rom_word(a) ^ {k, k};
    endfunction

    function automatic logic [23:0] map_reg(input int i);
        map_reg = {`OUTRUN_MAP_PAGE, 12'h000, i[2:0], 1'b0};
    endfunction

    task read_entry(input logic dec, input logic [23:0] a, input sel_t s, input word_t rd);
        entry_t e;
        e.rnw   = 1'b1;
        e.dec   = dec;
        e.addr  = a;
        e.wdata = 16'h0000;
        e.sel   = s;
        e.rdata = rd;
        tests.push_back(e);
    endtask

    task write_entry(input logic [23:0] a, input word_t wd, input sel_t s);
        entry_t e;
        e.rnw   = 1'b0;
        e.dec   = 1'b0;
        e.addr  = a;
        e.wdata = wd;
        e.sel   = s;
        e.rdata = 16'h0000;
        tests.push_back(e);
    endtask

    task build_table();
        logic [31:0]  r;
        logic [23:0]  a;
        byte_t        base_rst [6];
        base_rst = '{`OUTRUN_BASE0, `OUTRUN_BASE1, `OUTRUN_BASE2,
                     `OUTRUN_BASE3, `OUTRUN_BASE4, `OUTRUN_BASE5};
        for (int i = 0; i < 6; i++) begin
            read_entry(1'b0, map_reg(i), sel_map, {8'hFF, base_rst[i]});
        end
        // Regions at their reset bases
        read_entry(1'b0, 24'h000004, sel_rom, rom_word(24'h000004));
        read_entry(1'b0, 24'h00A01A, sel_rom, rom_word(24'h00A01A));
        read_entry(1'b0, 24'h401234, sel_vram, ram_word(24'h401234));
        read_entry(1'b0, 24'h840010, sel_pal, PAL_WORD);
        read_entry(1'b0, 24'h900020, sel_obj, OBJ_WORD);
        read_entry(1'b0, 24'hC40002, sel_io, {DIP_BYTE, JOY_BYTE});
        read_entry(1'b0, 24'h200000, sel_none, 16'hFFFF);
        read_entry(1'b0, 24'hFF0000, sel_none, 16'hFFFF);
        // Memory region moved to page 06, where A18:A17 pick work RAM
        write_entry(map_reg(0), 16'h0006, sel_map);
        read_entry(1'b0, map_reg(0), sel_map, 16'hFF06);
        read_entry(1'b0, 24'h000004, sel_none, 16'hFFFF);
        read_entry(1'b0, 24'h060010, sel_ram, ram_word(24'h060010));
        read_entry(1'b0, 24'h06ABC0, sel_ram, ram_word(24'h06ABC0));
        write_entry(24'h060100, 16'h1111, sel_ram);
        write_entry(map_reg(0), 16'h0000, sel_map);
        // Scroll region on an odd page reaches character RAM
        write_entry(map_reg(1), 16'h0041, sel_map);
        read_entry(1'b0, 24'h410040, sel_char, CHAR_WORD);
        read_entry(1'b0, 24'h401234, sel_none, 16'hFFFF);
        write_entry(map_reg(1), 16'h0040, sel_map);
        read_entry(1'b0, 24'h400800, sel_vram, ram_word(24'h400800));
        // Decrypted ROM, key index below KEYS
        read_entry(1'b1, 24'h000004, sel_rom, rom_crypt(24'h000004));
        read_entry(1'b1, 24'h00A01A, sel_rom, rom_crypt(24'h00A01A));
        read_entry(1'b1, 24'h00F00E, sel_rom, rom_crypt(24'h00F00E));
        read_entry(1'b1, 24'h001010, sel_rom, rom_crypt(24'h001010));
        read_entry(1'b0, 24'h001010, sel_rom, rom_word(24'h001010));
        for (int i = 0; i < 6; i++) begin
            draw_bits(15, r);
            a = {8'h00, r[14:0], 1'b0};
            read_entry(1'b0, a, sel_rom, rom_word(a));
            draw_bits(15, r);
            a = {8'h40, r[14:0], 1'b0};
            read_entry(1'b0, a, sel_vram, ram_word(a));
        end
    endtask

    task program_keys();
        for (int i = 0; i < KEYS; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= byte_t'(i);
            prog_data <= key_tab[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task run_entry(input entry_t e);
        logic [31:0]  r;
        int           start_cyc;
        int           exp_cyc;
        draw_bits(3, r);
        rom_delay = r[2:0];
        draw_bits(3, r);
        ram_delay = r[2:0];
        @(posedge clk);
        cpu_addr  <= e.addr[23:1];
        cpu_wdata <= e.wdata;
        cpu_rnw   <= e.rnw;
        cpu_dsn   <= 2'b00;
        dec_en    <= e.dec;
        cpu_asn   <= 1'b0;
        start_cyc = cycle + 1;
        do begin
            @(negedge clk);
        end while (cpu_dtackn);
        // Slow memories acknowledge a fixed time after their ok
        if (e.sel == sel_rom) begin
            exp_cyc = rom_ok_cyc + 2;
        end else if (e.sel == sel_ram || e.sel == sel_vram) begin
            exp_cyc = ram_ok_cyc + 1;
        end else begin
            exp_cyc = start_cyc + 2;
        end
        if (cycle != exp_cyc) begin
            fail_now($sformatf("DTACK for address %h came at cycle %0d instead of %0d",
                               e.addr, cycle, exp_cyc));
        end
        check_bit("rom_cs", rom_cs, e.sel == sel_rom);
        check_bit("ram_cs", ram_cs, e.sel == sel_ram);
        check_bit("vram_cs", vram_cs, e.sel == sel_vram);
        check_bit("char_cs", char_cs, e.sel == sel_char);
        check_bit("pal_cs", pal_cs, e.sel == sel_pal);
        check_bit("objram_cs", objram_cs, e.sel == sel_obj);
        check_bit("bus_rnw", bus_rnw, e.rnw);
        check_word("bus_wdata", bus_wdata, e.wdata);
        if (e.rnw) begin
            if (e.sel == sel_map) begin
                // Window register sits in the low byte
                check_byte("cpu_din[15:8]", cpu_din[15:8], e.rdata[15:8]);
                check_byte("cpu_din[7:0]", cpu_din[7:0], e.rdata[7:0]);
            end else begin
                check_word("cpu_din", cpu_din, e.rdata);
            end
        end
        @(posedge clk);
        cpu_asn <= 1'b1;
        cpu_rnw <= 1'b1;
        @(negedge clk);
        // Acknowledge holds until the strobe is seen high
        check_bit("cpu_dtackn", cpu_dtackn, 1'b0);
        @(negedge clk);
        check_bit("cpu_dtackn", cpu_dtackn, 1'b1);
        check_bit("any chip select", rom_cs | ram_cs | vram_cs | char_cs | pal_cs | objram_cs,
                  1'b0);
    endtask

    initial begin
        logic [31:0] r;
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_rnw   = 1'b1;
        cpu_asn   = 1'b1;
        cpu_dsn   = 2'b11;
        dec_en    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        lfsr      = 32'he8ecef28;
        for (int i = 0; i < KEYS; i++) begin
            draw_bits(8, r);
            key_tab[i] = r[7:0];
        end
        build_table();
        // Reset, key loading and a worst case of 20 clocks per bus cycle
        limit = tests.size() * 20 + 8 + KEYS + 4;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("any chip select", rom_cs | ram_cs | vram_cs | char_cs | pal_cs | objram_cs,
                  1'b0);
        check_bit("cpu_dtackn", cpu_dtackn, 1'b1);
        check_word("cpu_din", cpu_din, 16'h0000);
        program_keys();
        foreach (tests[i]) begin
            run_entry(tests[i]);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: project.f
+incdir+include
source/outrun_pkg.sv
source/cpu_bus_if.sv
source/outrun_mapper.sv
source/outrun_rom_decrypt.sv
source/outrun_dtack.sv
source/outrun_main_decode.sv
source/outrun_main.sv
tb/outrun_main_tb.sv

// File: Makefile
TOP := outrun_main_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
